// ==== include/img_preproc_cfg.svh ====
// Build-time constants for the image preprocessing adapter, included by the package and RTL
`ifndef IMG_PREPROC_CFG_SVH
`define IMG_PREPROC_CFG_SVH

// Grey weights in 1/256 units, the usual BT.601 split
// They should add up to 256 so that white maps to 255
`define IMG_LUMA_R 77
`define IMG_LUMA_G 150
`define IMG_LUMA_B 29

// Width of the x and y pixel coordinates
// The output word packs y, x and grey, so 12 bits gives a 32-bit word
// Any other value changes the output word width as well
`define IMG_COORD_BITS 12

`endif

// ==== verilog/img_preproc_pkg.sv ====
// Shared stream, pixel and output word types, referenced by scoped name from every module
`include "img_preproc_cfg.svh"

package img_preproc_pkg;

    // One pixel coordinate, x or y
    typedef logic [`IMG_COORD_BITS-1:0] coord_t;

    // First payload word of a frame
    // Only the width steers the decoder, the height is implied by the run total
    typedef struct packed {
        logic [15:0] width;
        logic [15:0] height;
    } header_t;

    // Every later payload word is one run of identical pixels
    typedef struct packed {
        logic [7:0] count;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } run_t;

    // The same 32 bits read as a header or as a run record
    typedef union packed {
        header_t hdr;
        run_t    run;
    } payload_u;

    // Payload word as handed from the framer to the decoder
    // strb marks the valid byte lanes, last flags the final word of the frame
    typedef struct packed {
        payload_u   data;
        logic [3:0] strb;
        logic       last;
    } frame_word_t;

    // One decoded pixel with its raster position
    typedef struct packed {
        coord_t     x;
        coord_t     y;
        logic [7:0] r;
        logic [7:0] g;
        logic [7:0] b;
    } pixel_t;

    // Output word, y in the top bits and grey in the bottom byte
    typedef struct packed {
        coord_t     y;
        coord_t     x;
        logic [7:0] grey;
    } out_word_t;

endpackage

// ==== verilog/stream_framer.sv ====
// Input framer that reads the byte length word of each frame and marks the payload words
module stream_framer (
    input  logic                      clock,
    input  logic                      reset,

    // Host side
    input  logic [31:0]               in_data_i,
    input  logic                      in_valid_i,
    output logic                      upstream_stall_o,

    // Decoder side
    output img_preproc_pkg::frame_word_t word_o,
    output logic                      word_valid_o,
    input  logic                      word_accept_i
);

    // Bytes still to come in the current frame
    // Zero between frames
    logic [31:0] byte_count;
    logic        in_frame;
    logic        word_fire;

    assign in_frame  = (byte_count != 32'd0);
    assign word_fire = word_valid_o && word_accept_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            byte_count <= 32'd0;
        end else if (!in_frame && in_valid_i) begin
            // A length word opens a frame
            // A zero length is just dropped and the framer stays idle
            if (in_data_i != 32'd0) begin
                byte_count <= in_data_i;
            end
        end else if (word_fire) begin
            // Each payload word eats four bytes
            // The last one may eat fewer
            byte_count <= (byte_count >= 32'd4) ? (byte_count - 32'd4) : 32'd0;
        end
    end

    // Payload words only exist inside a frame
    // The length word never goes downstream
    assign word_valid_o = in_valid_i && in_frame;

    always_comb begin
        word_o.data = in_data_i;
        word_o.last = in_frame && (byte_count <= 32'd4);
        // Full word unless fewer than four bytes remain
        // Valid bytes sit in the low lanes
        word_o.strb = 4'b1111;
        if (byte_count < 32'd4) begin
            case (byte_count[1:0])
                2'd1:    word_o.strb = 4'b0001;
                2'd2:    word_o.strb = 4'b0011;
                2'd3:    word_o.strb = 4'b0111;
                default: word_o.strb = 4'b1111;
            endcase
        end
    end

    // Between frames the length word is always taken
    // Inside a frame the host waits for the decoder
    assign upstream_stall_o = in_frame && !word_accept_i;

    // A stalled host keeps offering the same word until the framer takes it
    a_host_holds_word : assert property (
        @(posedge clock) disable iff (reset)
        in_valid_i && upstream_stall_o |=> in_valid_i && $stable(in_data_i)
    ) else $error("host changed or dropped its word while stalled");

endmodule

// ==== verilog/rle_decoder.sv ====
// Run-length RGB decoder: reads header and run record words and emits one pixel per cycle
module rle_decoder (
    input  logic                         clock,
    input  logic                         reset,

    // Payload words from the framer
    input  img_preproc_pkg::frame_word_t word_i,
    input  logic                         word_valid_i,
    output logic                         word_accept_o,

    // Pixels to the luma stage
    output img_preproc_pkg::pixel_t      pixel_o,
    output logic                         pixel_valid_o,
    input  logic                         stage_ready_i
);

    typedef enum logic {
        expect_header,
        expect_runs
    } state_t;

    state_t state;

    // Pixels left in the current run, zero means the run register is empty
    logic [7:0] run_left;
    logic [7:0] run_r;
    logic [7:0] run_g;
    logic [7:0] run_b;

    // Raster position of the pixel on offer and the last x of a line
    img_preproc_pkg::coord_t x_q;
    img_preproc_pkg::coord_t y_q;
    img_preproc_pkg::coord_t x_last;

    logic pixel_fire;
    logic last_pixel;
    logic word_fire;
    logic run_usable;

    assign pixel_valid_o = (run_left != 8'd0);
    assign pixel_fire    = pixel_valid_o && stage_ready_i;
    assign last_pixel    = pixel_fire && (run_left == 8'd1);

    // A new word is taken when the run register is empty or is being emptied now
    // This holds for a header too, so the tail run of the previous frame drains first
    assign word_accept_o = (run_left == 8'd0) || last_pixel;
    assign word_fire     = word_valid_i && word_accept_o;

    // Runs of zero length and records cut short by the frame end carry no pixels
    assign run_usable = (word_i.strb == 4'b1111) && (word_i.data.run.count != 8'd0);

    always_ff @(posedge clock) begin
        if (reset) begin
            state    <= expect_header;
            run_left <= 8'd0;
            x_q      <= '0;
            y_q      <= '0;
        end else begin
            if (pixel_fire) begin
                run_left <= run_left - 8'd1;
                // Step along the line and wrap at the stored width
                if (x_q == x_last) begin
                    x_q <= '0;
                    y_q <= y_q + 1'b1;
                end else begin
                    x_q <= x_q + 1'b1;
                end
            end
            if (word_fire) begin
                if (state == expect_header) begin
                    // A new frame restarts at the top left corner
                    x_q <= '0;
                    y_q <= '0;
                    if (!word_i.last) begin
                        state <= expect_runs;
                    end
                end else begin
                    if (run_usable) begin
                        run_left <= word_i.data.run.count;
                    end
                    if (word_i.last) begin
                        state <= expect_header;
                    end
                end
            end
        end
    end

    // Header width and run colour are plain payload registers
    always_ff @(posedge clock) begin
        if (word_fire && (state == expect_header)) begin
            x_last <= img_preproc_pkg::coord_t'(word_i.data.hdr.width - 16'd1);
        end
        if (word_fire && (state == expect_runs) && run_usable) begin
            run_r <= word_i.data.run.r;
            run_g <= word_i.data.run.g;
            run_b <= word_i.data.run.b;
        end
    end

    always_comb begin
        pixel_o.x = x_q;
        pixel_o.y = y_q;
        pixel_o.r = run_r;
        pixel_o.g = run_g;
        pixel_o.b = run_b;
    end

    // A pixel on offer must wait unchanged until the luma stage takes it
    a_pixel_hold : assert property (
        @(posedge clock) disable iff (reset)
        pixel_valid_o && !stage_ready_i |=> pixel_valid_o && $stable(pixel_o)
    ) else $error("decoder changed a pixel before the luma stage took it");

endmodule

// ==== verilog/luma_converter.sv ====
// Output register stage: turns an RGB pixel into grey and packs it with its coordinates
`include "img_preproc_cfg.svh"

module luma_converter (
    input  logic                       clock,
    input  logic                       reset,

    // Pixels from the decoder
    input  img_preproc_pkg::pixel_t    pixel_i,
    input  logic                       pixel_valid_i,
    output logic                       stage_ready_o,

    // Output side
    output img_preproc_pkg::out_word_t out_data_o,
    output logic                       out_valid_o,
    input  logic                       downstream_stall_i
);

    // Weighted sum of the three channels, at most 255 * 256
    logic [17:0] luma_sum;

    always_comb begin
        luma_sum = 18'(pixel_i.r * `IMG_LUMA_R + pixel_i.g * `IMG_LUMA_G
                       + pixel_i.b * `IMG_LUMA_B);
    end

    // The register may load when it is empty or its word leaves this cycle
    assign stage_ready_o = !out_valid_o || !downstream_stall_i;

    always_ff @(posedge clock) begin
        if (reset) begin
            out_valid_o <= 1'b0;
        end else if (stage_ready_o) begin
            out_valid_o <= pixel_valid_i;
        end
    end

    always_ff @(posedge clock) begin
        if (stage_ready_o && pixel_valid_i) begin
            out_data_o.y    <= pixel_i.y;
            out_data_o.x    <= pixel_i.x;
            // Divide by 256 to undo the weight scale
            out_data_o.grey <= luma_sum[15:8];
        end
    end

    // The host sees the same word for as long as it stalls
    a_out_hold : assert property (
        @(posedge clock) disable iff (reset)
        out_valid_o && downstream_stall_i |=> out_valid_o && $stable(out_data_o)
    ) else $error("output word changed while the host was stalling");

endmodule

// ==== verilog/img_preproc_top.sv ====
// Top level of the image preprocessing adapter, the block the host bus logic instantiates
module img_preproc_top (
    input  logic                       clock,
    input  logic                       reset,

    // Word stream from the host, first word of each frame is the byte length
    input  logic [31:0]                in_data_i,
    input  logic                       in_valid_i,
    output logic                       upstream_stall_o,

    // One packed {y, x, grey} word per pixel
    output img_preproc_pkg::out_word_t out_data_o,
    output logic                       out_valid_o,
    input  logic                       downstream_stall_i
);

    // Framer to decoder
    img_preproc_pkg::frame_word_t frame_word;
    logic                         word_valid;
    logic                         word_accept;

    // Decoder to luma stage
    img_preproc_pkg::pixel_t      pixel;
    logic                         pixel_valid;
    logic                         stage_ready;

    // Frames the host stream and flags the strobe and last word
    stream_framer i_stream_framer (
        .clock            (clock),
        .reset            (reset),
        .in_data_i        (in_data_i),
        .in_valid_i       (in_valid_i),
        .upstream_stall_o (upstream_stall_o),
        .word_o           (frame_word),
        .word_valid_o     (word_valid),
        .word_accept_i    (word_accept)
    );

    // Expands run records into a raster of pixels
    rle_decoder i_rle_decoder (
        .clock         (clock),
        .reset         (reset),
        .word_i        (frame_word),
        .word_valid_i  (word_valid),
        .word_accept_o (word_accept),
        .pixel_o       (pixel),
        .pixel_valid_o (pixel_valid),
        .stage_ready_i (stage_ready)
    );

    // Grey conversion and the output register
    luma_converter i_luma_converter (
        .clock              (clock),
        .reset              (reset),
        .pixel_i            (pixel),
        .pixel_valid_i      (pixel_valid),
        .stage_ready_o      (stage_ready),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .downstream_stall_i (downstream_stall_i)
    );

endmodule

// ==== bench/img_preproc_tb.sv ====
// Self-checking testbench for the adapter that sends random run-length frames and checks the pixels
`include "img_preproc_cfg.svh"

module img_preproc_tb;

    localparam int NUM_FRAMES       = 40;
    localparam int CYCLES_PER_FRAME = 400;
    // Reset, the idle check after reset and the final drain
    localparam int SETTLE_CYCLES    = 60;
    localparam int TIMEOUT_CYCLES   = NUM_FRAMES * CYCLES_PER_FRAME + SETTLE_CYCLES;
    localparam int STALL_LEN        = 16384;

    logic                       clock;
    logic                       reset;
    logic [31:0]                in_data_i;
    logic                       in_valid_i;
    logic                       upstream_stall_o;
    img_preproc_pkg::out_word_t out_data_o;
    logic                       out_valid_o;
    logic                       downstream_stall_i;

    // Pixels still owed by the DUT with the oldest at the front
    img_preproc_pkg::out_word_t expected_q[$];

    // Stall level for each cycle drawn from the seeded sequence before any frame is built
    bit                         stall_pattern[STALL_LEN];
    int                         cycle_count = 0;

    // Output word seen under a stall on the previous edge
    logic                       held_valid = 1'b0;
    img_preproc_pkg::out_word_t held_word;

    img_preproc_top i_img_preproc_top (
        .clock              (clock),
        .reset              (reset),
        .in_data_i          (in_data_i),
        .in_valid_i         (in_valid_i),
        .upstream_stall_o   (upstream_stall_o),
        .out_data_o         (out_data_o),
        .out_valid_o        (out_valid_o),
        .downstream_stall_i (downstream_stall_i)
    );

    initial clock = 1'b0;
    always #10 clock = ~clock;

    task automatic abort_run();
        $display("Simulation FAILED");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic compare_out(input string what, input img_preproc_pkg::out_word_t expected,
                               input img_preproc_pkg::out_word_t actual);
        string exp_text;
        string act_text;
        if (actual !== expected) begin
            exp_text = $sformatf("y=%0d x=%0d grey=%0d", expected.y, expected.x, expected.grey);
            act_text = $sformatf("y=%0d x=%0d grey=%0d", actual.y, actual.x, actual.grey);
            $display("FAILED at time %0t: %s expected %s, got %s",
                     $time, what, exp_text, act_text);
            abort_run();
        end
    endtask

    task automatic compare_flag(input string what, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("FAILED at time %0t: %s expected %b, got %b", $time, what, expected, actual);
            abort_run();
        end
    endtask

    // Reference grey value with BT.601 weights in 1/256 units
    function automatic int grey_of(input int r, input int g, input int b);
        return (`IMG_LUMA_R * r + `IMG_LUMA_G * g + `IMG_LUMA_B * b) >> 8;
    endfunction

    // Offers one word after a random idle gap and holds it until the DUT takes it
    task automatic send_word(input logic [31:0] word);
        int  gap;
        logic taken;
        gap = $urandom % 3;
        repeat (gap) begin
            in_valid_i = 1'b0;
            @(posedge clock);
            #2;
        end
        in_data_i  = word;
        in_valid_i = 1'b1;
        taken      = 1'b0;
        while (!taken) begin
            @(posedge clock);
            taken = !upstream_stall_o;
            #2;
        end
    endtask

    // Builds one frame, queues its expected pixels in raster order and sends it
    task automatic send_frame();
        img_preproc_pkg::payload_u  pw;
        img_preproc_pkg::out_word_t ow;
        logic [31:0]                words_q[$];
        int width;
        int height;
        int remaining;
        int count;
        int pixel;
        int pad;
        width  = 1 + $urandom % 8;
        height = 1 + $urandom % 4;
        pw.hdr.width  = 16'(width);
        pw.hdr.height = 16'(height);
        words_q.push_back(pw);
        remaining = width * height;
        pixel     = 0;
        while (remaining > 0) begin
            pw.run.r = 8'($urandom);
            pw.run.g = 8'($urandom);
            pw.run.b = 8'($urandom);
            // Empty runs are mixed in and must not move the raster position
            if ($urandom % 5 == 0) begin
                count = 0;
            end else begin
                count = 1 + $urandom % ((remaining < 6) ? remaining : 6);
            end
            pw.run.count = 8'(count);
            words_q.push_back(pw);
            repeat (count) begin
                ow.x    = img_preproc_pkg::coord_t'(pixel % width);
                ow.y    = img_preproc_pkg::coord_t'(pixel / width);
                ow.grey = 8'(grey_of(pw.run.r, pw.run.g, pw.run.b));
                expected_q.push_back(ow);
                pixel++;
            end
            remaining -= count;
        end
        // A stray byte past the last record ends the frame on a partial word
        pad = ($urandom % 3 == 0) ? 1 : 0;
        if (pad != 0) begin
            words_q.push_back($urandom);
        end
        if ($urandom % 4 == 0) begin
            send_word(32'd0);
        end
        send_word(32'(4 * (words_q.size() - pad) + pad));
        foreach (words_q[i]) begin
            send_word(words_q[i]);
        end
    endtask

    // Stall changes 2 units after the edge like every other input
    always @(posedge clock) begin
        #2;
        downstream_stall_i = reset ? 1'b0 : stall_pattern[cycle_count % STALL_LEN];
        cycle_count = cycle_count + 1;
    end

    // A word leaves the DUT on an edge with valid high and no stall
    always @(posedge clock) begin
        if (!reset) begin
            if (held_valid) begin
                compare_flag("out_valid_o under stall", 1'b1, out_valid_o);
                compare_out("out_data_o under stall", held_word, out_data_o);
            end
            if (out_valid_o && !downstream_stall_i) begin
                if (expected_q.size() == 0) begin
                    $display("An output word arrived when no more pixels were expected");
                    abort_run();
                end else begin
                    compare_out("pixel", expected_q.pop_front(), out_data_o);
                end
            end
            held_valid = out_valid_o && downstream_stall_i;
            held_word  = out_data_o;
        end
    end

    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clock);
        $display("Output stopped arriving before all expected pixels were seen");
        abort_run();
    end

    initial begin
        reset              = 1'b1;
        in_data_i          = 32'd0;
        in_valid_i         = 1'b0;
        downstream_stall_i = 1'b0;
        void'($urandom(32'hefa1));
        for (int i = 0; i < STALL_LEN; i++) begin
            stall_pattern[i] = ($urandom % 10) < 3;
        end
        repeat (4) @(posedge clock);
        #2;
        reset = 1'b0;
        // With no input the DUT must stay quiet on both sides
        repeat (10) begin
            @(posedge clock);
            compare_flag("out_valid_o while idle", 1'b0, out_valid_o);
            compare_flag("upstream_stall_o while idle", 1'b0, upstream_stall_o);
        end
        #2;
        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame();
        end
        in_valid_i = 1'b0;
        while (expected_q.size() != 0) begin
            @(posedge clock);
            #1;
        end
        // Extra words after the last frame would show up here
        repeat (20) @(posedge clock);
        $display("Simulation PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
verilog/img_preproc_pkg.sv
verilog/stream_framer.sv
verilog/rle_decoder.sv
verilog/luma_converter.sv
verilog/img_preproc_top.sv
bench/img_preproc_tb.sv
